//--- Bender.yml
package:
  name: pcie_tlp_handler

sources:
  - files:
      - common/tlp_pkg.sv
      - common/tlp_frame_if.sv
      - rx/tlp_rx_decoder.sv
      - rtl/mem_request_encoder.sv
      - tx/cpl_builder.sv
      - rtl/tlp_stats_csr.sv
      - rtl/pcie_tlp_handler.sv
  - target: test
    files:
      - dv/tb_pcie_tlp_handler.sv

//--- common/tlp_frame_if.sv
`timescale 1ns/100ps
// Fields of the RX frame currently being handled
interface tlp_frame_if;

  tlp_pkg::tlp_kind_e               kind;
  logic [tlp_pkg::REQ_ID_W-1:0]     requester_id;
  logic [tlp_pkg::TAG_W-1:0]        tag;
  logic [tlp_pkg::DW_W-1:0]         address;       // Dword aligned
  logic [tlp_pkg::DW_W-1:0]         data;          // First payload dword
  logic [tlp_pkg::BYTE_CNT_W-1:0]   byte_count;
  logic [6:0]                       lower_address;
  logic                             is_npr;        // Needs a completion
  logic                             is_pr;         // Posted, no completion
  logic                             unsupported;
  logic                             frm_start;     // One-cycle pulses
  logic                             frm_end;

  modport decoder (
    output kind, requester_id, tag, address, data, byte_count, lower_address,
    output is_npr, is_pr, unsupported,
    output frm_start, frm_end
  );

  modport consumer (
    input kind, requester_id, tag, address, data, byte_count, lower_address,
    input is_npr, is_pr, unsupported,
    input frm_start, frm_end
  );

endinterface

//--- common/tlp_pkg.sv
package tlp_pkg;

  localparam int DATA_W     = 256; // Avalon-ST beat
  localparam int DW_W       = 32;
  localparam int REQ_ID_W   = 16;  // Requester and completer ID
  localparam int TAG_W      = 8;
  localparam int MEM_REQ_W  = 128; // Memory access request and response
  localparam int BYTE_CNT_W = 12;
  localparam int LEN_W      = 10;

  // Fmt field codes, 3-DW header variants
  localparam logic [2:0] FMT_MRD  = 3'b000;
  localparam logic [2:0] FMT_MWR  = 3'b010; // With data
  localparam logic [2:0] FMT_CPL  = 3'b000;
  localparam logic [2:0] FMT_CPLD = 3'b010; // With data

  // Type field codes
  localparam logic [4:0] TYPE_MRD   = 5'b00000;
  localparam logic [4:0] TYPE_MRDLK = 5'b00001;
  localparam logic [4:0] TYPE_MWR   = 5'b00000;
  localparam logic [4:0] TYPE_CPL   = 5'b01010;
  localparam logic [4:0] TYPE_CPLD  = 5'b01010;

  typedef enum logic [2:0] {
    TLP_MRD,
    TLP_MRDLK,
    TLP_MWR,
    TLP_CPL,
    TLP_CPLD,
    TLP_UNKNOWN
  } tlp_kind_e;

  typedef enum logic [2:0] {
    CPL_SC = 3'd0, // Successful completion
    CPL_UR = 3'd1  // Unsupported request
  } cpl_status_e;

  typedef enum logic [5:0] {
    CSR_ID       = 6'd0,
    CSR_RX_COUNT = 6'd1,
    CSR_TX_COUNT = 6'd2
  } csr_reg_e;

  // Disabled bytes below the lowest enabled byte
  function automatic logic [1:0] low_gap(input logic [3:0] be);
    casez (be)
      4'b???1: low_gap = 2'd0;
      4'b??10: low_gap = 2'd1;
      4'b?100: low_gap = 2'd2;
      default: low_gap = 2'd3;
    endcase
  endfunction

  // Disabled bytes above the highest enabled byte
  function automatic logic [1:0] high_gap(input logic [3:0] be);
    casez (be)
      4'b1???: high_gap = 2'd0;
      4'b01??: high_gap = 2'd1;
      4'b001?: high_gap = 2'd2;
      default: high_gap = 2'd3;
    endcase
  endfunction

  // Total byte count of a request from length and byte enables
  function automatic logic [BYTE_CNT_W-1:0] byte_count(input logic [LEN_W-1:0] len,
                                                       input logic [3:0] first_be,
                                                       input logic [3:0] last_be);
    logic [BYTE_CNT_W-1:0] total;
    total = {len, 2'b00};
    if (last_be == 4'b0000) begin
      // Single dword, span from lowest to highest enabled byte
      if (first_be == 4'b0000)
        byte_count = BYTE_CNT_W'(1); // Zero-length read still counts one
      else
        byte_count = BYTE_CNT_W'(4) - BYTE_CNT_W'(low_gap(first_be))
                     - BYTE_CNT_W'(high_gap(first_be));
    end else if (first_be == 4'b0000) begin
      byte_count = '0; // Invalid combination
    end else begin
      byte_count = total - BYTE_CNT_W'(low_gap(first_be)) - BYTE_CNT_W'(high_gap(last_be));
    end
  endfunction

endpackage

//--- dv/tb_pcie_tlp_handler.sv
`timescale 1ns/100ps
module tb_pcie_tlp_handler;

  localparam int BAR_ADDR_BITS = 19;
  localparam logic [15:0] COMPLETER_ID = 16'h0a10;
  localparam int N_WR = 8;
  localparam int N_RD = 8;
  localparam int N_TRANS = N_WR + 2 * N_RD + 4 + 4; // Reads and their answers count twice
  localparam int CYCLE_LIMIT = 40 * N_TRANS + 100;

  logic clk = 1'b0;
  logic reset;
  logic [255:0] rx_st_data;
  logic rx_st_valid, rx_st_startofpacket, rx_st_endofpacket, rx_st_ready;
  logic [255:0] tx_st_data;
  logic tx_st_valid, tx_st_startofpacket, tx_st_endofpacket;
  logic [127:0] mem_access_req_data;
  logic mem_access_req_valid;
  logic [127:0] mem_access_resp_data;
  logic mem_access_resp_valid, mem_access_resp_ready;
  logic csr_read;
  logic [5:0] csr_address;
  logic [31:0] csr_readdata;
  logic [15:0] cfg_completer_id;
  logic cfg_id_valid;
  logic [6:0] cpl_err;

  integer seed;
  int unsigned cycle = 0;
  int rx_sent = 0;      // RX packets driven
  int tx_expected = 0;  // Completions queued

  // Expected items with the sampling cycle they belong to
  logic [127:0] exp_req_data[$];
  int unsigned  exp_req_cycle[$];
  logic [255:0] exp_tx_data[$];
  int unsigned  exp_tx_cycle[$];
  logic [6:0]   exp_err[$];
  int unsigned  exp_err_cycle[$];

  always #5 clk = ~clk;

  pcie_tlp_handler #(.BAR_ADDR_BITS(BAR_ADDR_BITS)) i_dut (.*);

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_equal(input string what, input logic [255:0] actual,
                             input logic [255:0] expected);
    if (actual !== expected)
      abort_run($sformatf("Fail at %0t ns: %s, got %0h, expected %0h",
                          $time, what, actual, expected));
  endtask

  // Single-beat RX request with the payload after the header
  function automatic logic [255:0] make_request(input bit is_write, input bit four_dw,
                                                input logic [9:0] len, input logic [15:0] rid,
                                                input logic [7:0] tag, input logic [31:0] addr,
                                                input logic [31:0] data);
    logic [255:0] beat;
    logic [3:0]   last_be;
    beat = '0;
    last_be = (len > 10'd1) ? 4'hf : 4'h0;
    beat[31:0] = {1'b0, is_write, four_dw, 5'b00000, 14'h0, len};
    beat[63:32] = {rid, tag, last_be, 4'hf};
    if (four_dw) begin
      beat[127:96]  = addr;  // Upper address dword left zero
      beat[159:128] = data;
    end else begin
      beat[95:64]  = addr;
      beat[127:96] = data;
    end
    return beat;
  endfunction

  function automatic logic [127:0] mem_request(input bit is_write, input logic [31:0] addr,
                                               input logic [31:0] data, input logic [15:0] rid,
                                               input logic [7:0] tag);
    logic [127:0] word;
    word = '0;
    word[0] = is_write;
    if (is_write) begin
      word[32:1] = data;
    end else begin
      word[16:1]  = rid;
      word[24:17] = tag;
    end
    word[94:33] = 62'(addr[BAR_ADDR_BITS-1:2]);  // Dword index in the window
    return word;
  endfunction

  // Full byte enables give four bytes per dword
  function automatic logic [255:0] ur_completion(input logic [15:0] rid, input logic [7:0] tag,
                                                 input logic [31:0] addr, input logic [9:0] len);
    logic [255:0] beat;
    beat = '0;
    beat[31:0]  = {3'b000, 5'b01010, 24'h0};  // Cpl header with zero length
    beat[63:32] = {COMPLETER_ID, 3'b001, 1'b0, len, 2'b00};
    beat[95:64] = {rid, tag, 1'b0, addr[6:2], 2'b00};
    return beat;
  endfunction

  function automatic logic [255:0] cpld_completion(input logic [15:0] rid, input logic [7:0] tag,
                                                   input logic [31:0] addr,
                                                   input logic [31:0] rdata);
    logic [255:0] beat;
    beat = '0;
    beat[31:0]  = {3'b010, 5'b01010, 14'h0, 10'd1};
    beat[63:32] = {COMPLETER_ID, 3'b000, 1'b0, 12'd4};
    beat[95:64] = {rid, tag, 1'b0, addr[6:2], 2'b00};
    if (addr[2])
      beat[127:96] = rdata;
    else
      beat[159:128] = rdata;  // Pad dword keeps 8-byte alignment
    return beat;
  endfunction

  function automatic logic [6:0] error_bits(input bit posted);
    return posted ? 7'b001_0000 : 7'b010_0000;
  endfunction

  task automatic send_tlp(input logic [255:0] beat, output int unsigned drive_cycle);
    @(posedge clk);
    rx_st_data          <= beat;
    rx_st_valid         <= 1'b1;
    rx_st_startofpacket <= 1'b1;
    rx_st_endofpacket   <= 1'b1;
    drive_cycle = cycle;
    rx_sent++;
    @(posedge clk);
    rx_st_valid         <= 1'b0;
    rx_st_startofpacket <= 1'b0;
    rx_st_endofpacket   <= 1'b0;
  endtask

  task automatic send_response(input logic [127:0] word, output int unsigned drive_cycle);
    @(posedge clk);
    mem_access_resp_data  <= word;
    mem_access_resp_valid <= 1'b1;
    drive_cycle = cycle;
    @(posedge clk);
    mem_access_resp_valid <= 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_req_data.size() + exp_tx_data.size() + exp_err.size() != 0)
      @(posedge clk);
    repeat (3) @(posedge clk);  // Room for stray pulses
  endtask

  task automatic read_csr(input logic [5:0] addr, output logic [31:0] value);
    @(posedge clk);
    csr_read    <= 1'b1;
    csr_address <= addr;
    @(posedge clk);
    csr_read <= 1'b0;
    @(posedge clk);
    value = csr_readdata;
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT)
      abort_run($sformatf("Timeout: run still going after %0d cycles", cycle));
  end

  // Compare each output pulse with the next expected item
  always @(posedge clk) begin
    if (!reset && mem_access_req_valid === 1'b1) begin
      if (exp_req_data.size() == 0)
        abort_run("Memory request issued with none expected");
      else begin
        check_equal("memory request cycle", cycle, exp_req_cycle.pop_front());
        check_equal("memory request word", mem_access_req_data, exp_req_data.pop_front());
      end
    end
    if (!reset && tx_st_valid === 1'b1) begin
      if (exp_tx_data.size() == 0)
        abort_run("TX TLP sent with none expected");
      else begin
        check_equal("TX cycle", cycle, exp_tx_cycle.pop_front());
        check_equal("TX sop and eop", {tx_st_startofpacket, tx_st_endofpacket}, 2'b11);
        check_equal("TX beat", tx_st_data, exp_tx_data.pop_front());
      end
    end
    if (!reset && cpl_err !== 7'b0) begin
      if (exp_err.size() == 0)
        abort_run($sformatf("Completion error bits %b raised with none expected", cpl_err));
      else begin
        check_equal("cpl_err cycle", cycle, exp_err_cycle.pop_front());
        check_equal("cpl_err bits", cpl_err, exp_err.pop_front());
      end
    end
  end

  initial begin
    logic [31:0]  addr;
    logic [31:0]  data;
    logic [15:0]  rid;
    logic [7:0]   tag;
    logic [31:0]  value;
    logic [127:0] resp;
    int unsigned  c;
    seed = 27957;
    reset                 <= 1'b1;
    rx_st_data            <= '0;
    rx_st_valid           <= 1'b0;
    rx_st_startofpacket   <= 1'b0;
    rx_st_endofpacket     <= 1'b0;
    mem_access_resp_data  <= '0;
    mem_access_resp_valid <= 1'b0;
    csr_read              <= 1'b0;
    csr_address           <= '0;
    cfg_completer_id      <= COMPLETER_ID;
    cfg_id_valid          <= 1'b0;
    repeat (10) @(posedge clk);
    reset        <= 1'b0;
    cfg_id_valid <= 1'b1;
    repeat (2) @(posedge clk);
    check_equal("RX ready", rx_st_ready, 1'b1);
    check_equal("response ready", mem_access_resp_ready, 1'b1);

    // Supported 1-DW writes
    for (int i = 0; i < N_WR; i++) begin
      addr = $random(seed) & 32'hffff_fffc;
      data = $random(seed);
      rid  = 16'($random(seed));
      tag  = 8'($random(seed));
      send_tlp(make_request(1'b1, 1'b0, 10'd1, rid, tag, addr, data), c);
      exp_req_data.push_back(mem_request(1'b1, addr, data, rid, tag));
      exp_req_cycle.push_back(c + 3);
      wait_drained();
    end

    // Reads answered with both alignments
    for (int i = 0; i < N_RD; i++) begin
      addr = {29'($random(seed)), i[0], 2'b00};
      data = $random(seed);
      rid  = 16'($random(seed));
      tag  = 8'($random(seed));
      send_tlp(make_request(1'b0, 1'b0, 10'd1, rid, tag, addr, 32'h0), c);
      exp_req_data.push_back(mem_request(1'b0, addr, 32'h0, rid, tag));
      exp_req_cycle.push_back(c + 3);
      wait_drained();
      resp = '0;
      resp[15:0]  = rid;
      resp[23:16] = tag;
      resp[28:24] = addr[6:2];
      resp[63:32] = data;
      send_response(resp, c);
      exp_tx_data.push_back(cpld_completion(rid, tag, addr, data));
      exp_tx_cycle.push_back(c + 2);
      tx_expected++;
      wait_drained();
    end

    // Two-dword reads get UR
    for (int i = 0; i < 2; i++) begin
      addr = $random(seed) & 32'hffff_fffc;
      rid  = 16'($random(seed));
      tag  = 8'($random(seed));
      send_tlp(make_request(1'b0, 1'b0, 10'd2, rid, tag, addr, 32'h0), c);
      exp_err.push_back(error_bits(1'b0));
      exp_err_cycle.push_back(c + 2);
      exp_tx_data.push_back(ur_completion(rid, tag, addr, 10'd2));
      exp_tx_cycle.push_back(c + 3);
      tx_expected++;
      wait_drained();
    end

    // Dropped posted writes with length 2 or a 4-DW header
    for (int i = 0; i < 2; i++) begin
      addr = $random(seed) & 32'hffff_fffc;
      data = $random(seed);
      send_tlp(make_request(1'b1, i == 1, (i == 1) ? 10'd1 : 10'd2, 16'h0101, 8'h11,
                            addr, data), c);
      exp_err.push_back(error_bits(1'b1));
      exp_err_cycle.push_back(c + 2);
      wait_drained();
    end

    read_csr(6'd0, value);
    check_equal("CSR completer ID", value, {16'h0, COMPLETER_ID});
    read_csr(6'd1, value);
    check_equal("CSR RX count", value, rx_sent);
    read_csr(6'd2, value);
    check_equal("CSR TX count", value, tx_expected);
    read_csr(6'd7, value);
    check_equal("CSR unmapped", value, 32'hffff_ffff);

    if (exp_req_data.size() + exp_tx_data.size() + exp_err.size() == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      abort_run("Expected outputs never appeared");
    end
  end

endmodule

//--- rtl/mem_request_encoder.sv
`timescale 1ns/100ps
module mem_request_encoder #(
  parameter int BAR_ADDR_BITS = 19
) (
  input  logic                          clk,
  input  logic                          reset,
  tlp_frame_if.consumer                 frame,
  output logic [tlp_pkg::MEM_REQ_W-1:0] mem_access_req_data,
  output logic                          mem_access_req_valid
);

  // Window mask, BAR region must cover lower address bits
  localparam logic [tlp_pkg::DW_W-1:0] BAR_MASK = (32'd1 << BAR_ADDR_BITS) - 32'd1;

  logic [tlp_pkg::DW_W-1:0] masked_address;
  logic                     is_mem;  // MRd or MWr in the frame
  logic                     post;

  assign masked_address = frame.address & BAR_MASK;
  assign is_mem = (frame.kind == tlp_pkg::TLP_MRD) || (frame.kind == tlp_pkg::TLP_MWR);
  assign post   = frame.frm_end & ~frame.unsupported & is_mem;

  always_ff @(posedge clk) begin
    if (reset)
      mem_access_req_valid <= 1'b0;
    else
      mem_access_req_valid <= post;
  end

  // Request word, upper 33 bits always zero
  always_ff @(posedge clk) begin
    if (post) begin
      if (frame.kind == tlp_pkg::TLP_MWR)
        mem_access_req_data <= {33'b0, 32'b0, masked_address[31:2], frame.data, 1'b1};
      else
        mem_access_req_data <= {33'b0, 32'b0, masked_address[31:2],
                                8'b0, frame.tag, frame.requester_id, 1'b0}; // Read
    end
  end

endmodule

//--- rtl/pcie_tlp_handler.sv
`timescale 1ns/100ps
module pcie_tlp_handler #(
  parameter int BAR_ADDR_BITS = 19  // 512 KiB window, 7 or more
) (
  input  logic                          clk,
  input  logic                          reset,
  // RX stream from the hard IP
  input  logic [tlp_pkg::DATA_W-1:0]    rx_st_data,
  input  logic                          rx_st_valid,
  input  logic                          rx_st_startofpacket,
  input  logic                          rx_st_endofpacket,
  output logic                          rx_st_ready,
  // TX stream to the hard IP
  output logic [tlp_pkg::DATA_W-1:0]    tx_st_data,
  output logic                          tx_st_valid,
  output logic                          tx_st_startofpacket,
  output logic                          tx_st_endofpacket,
  // Memory side
  output logic [tlp_pkg::MEM_REQ_W-1:0] mem_access_req_data,
  output logic                          mem_access_req_valid,
  input  logic [tlp_pkg::MEM_REQ_W-1:0] mem_access_resp_data,
  input  logic                          mem_access_resp_valid,
  output logic                          mem_access_resp_ready,
  // CSR
  input  logic                          csr_read,
  input  logic [5:0]                    csr_address,
  output logic [31:0]                   csr_readdata,
  // Configuration
  input  logic [tlp_pkg::REQ_ID_W-1:0]  cfg_completer_id,
  input  logic                          cfg_id_valid,
  output logic [6:0]                    cpl_err
);

  tlp_frame_if frame ();

  assign rx_st_ready           = cfg_id_valid; // Idle until bus number known
  assign mem_access_resp_ready = cfg_id_valid;

  tlp_rx_decoder i_rx_decoder (
    .clk                 (clk),
    .reset               (reset),
    .id_valid            (cfg_id_valid),
    .rx_st_data          (rx_st_data),
    .rx_st_valid         (rx_st_valid),
    .rx_st_startofpacket (rx_st_startofpacket),
    .rx_st_endofpacket   (rx_st_endofpacket),
    .frame               (frame)
  );

  mem_request_encoder #(
    .BAR_ADDR_BITS (BAR_ADDR_BITS)
  ) i_mem_request_encoder (
    .clk                  (clk),
    .reset                (reset),
    .frame                (frame),
    .mem_access_req_data  (mem_access_req_data),
    .mem_access_req_valid (mem_access_req_valid)
  );

  cpl_builder i_cpl_builder (
    .clk                   (clk),
    .reset                 (reset),
    .completer_id          (cfg_completer_id),
    .frame                 (frame),
    .mem_access_resp_data  (mem_access_resp_data),
    .mem_access_resp_valid (mem_access_resp_valid),
    .tx_st_data            (tx_st_data),
    .tx_st_valid           (tx_st_valid),
    .tx_st_startofpacket   (tx_st_startofpacket),
    .tx_st_endofpacket     (tx_st_endofpacket),
    .cpl_err               (cpl_err)
  );

  tlp_stats_csr i_stats_csr (
    .clk                 (clk),
    .reset               (reset),
    .id_valid            (cfg_id_valid),
    .completer_id        (cfg_completer_id),
    .rx_st_valid         (rx_st_valid),
    .rx_st_startofpacket (rx_st_startofpacket),
    .tx_st_valid         (tx_st_valid),
    .csr_read            (csr_read),
    .csr_address         (csr_address),
    .csr_readdata        (csr_readdata)
  );

endmodule

//--- rtl/tlp_stats_csr.sv
`timescale 1ns/100ps
module tlp_stats_csr (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         id_valid,
  input  logic [tlp_pkg::REQ_ID_W-1:0] completer_id,
  input  logic                         rx_st_valid,
  input  logic                         rx_st_startofpacket,
  input  logic                         tx_st_valid,
  input  logic                         csr_read,
  input  logic [5:0]                   csr_address,
  output logic [31:0]                  csr_readdata
);

  logic [31:0] rx_count; // Accepted RX packets
  logic [31:0] tx_count; // Completions sent

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_count <= '0;
      tx_count <= '0;
    end else begin
      if (id_valid && rx_st_valid && rx_st_startofpacket)
        rx_count <= rx_count + 32'd1;
      if (tx_st_valid)
        tx_count <= tx_count + 32'd1; // Every TX beat is a whole TLP
    end
  end

  // Registered read port
  always_ff @(posedge clk) begin
    if (reset) begin
      csr_readdata <= '0;
    end else if (csr_read) begin
      case (csr_address)
        tlp_pkg::CSR_ID:       csr_readdata <= {16'b0, completer_id};
        tlp_pkg::CSR_RX_COUNT: csr_readdata <= rx_count;
        tlp_pkg::CSR_TX_COUNT: csr_readdata <= tx_count;
        default:               csr_readdata <= 32'hffff_ffff; // Unmapped
      endcase
    end
  end

endmodule

//--- rx/tlp_rx_decoder.sv
`timescale 1ns/100ps
module tlp_rx_decoder (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       id_valid,
  input  logic [tlp_pkg::DATA_W-1:0] rx_st_data,
  input  logic                       rx_st_valid,
  input  logic                       rx_st_startofpacket,
  input  logic                       rx_st_endofpacket,
  tlp_frame_if.decoder               frame
);

  logic [7:0][tlp_pkg::DW_W-1:0] dword;   // Beat as header/payload dwords
  logic [2:0]                    fmt;
  logic [4:0]                    raw_type;
  logic [tlp_pkg::LEN_W-1:0]     len;
  logic                          is_4dw;
  tlp_pkg::tlp_kind_e            kind;    // Kind of the beat on the bus
  logic                          accept;  // New packet taken in
  logic [tlp_pkg::LEN_W-1:0]     frm_len;
  logic                          frm_is_4dw;

  assign dword    = rx_st_data;
  assign fmt      = dword[0][31:29];
  assign raw_type = dword[0][28:24];
  assign len      = dword[0][9:0];
  assign is_4dw   = fmt[0];           // 64-bit address header
  assign accept   = id_valid & rx_st_valid & rx_st_startofpacket;

  // Header only tells data/no-data and type apart here
  always_comb begin
    case ({fmt[1], raw_type})
      {tlp_pkg::FMT_MRD[1], tlp_pkg::TYPE_MRD}:     kind = tlp_pkg::TLP_MRD;
      {tlp_pkg::FMT_MRD[1], tlp_pkg::TYPE_MRDLK}:   kind = tlp_pkg::TLP_MRDLK;
      {tlp_pkg::FMT_MWR[1], tlp_pkg::TYPE_MWR}:     kind = tlp_pkg::TLP_MWR;
      {tlp_pkg::FMT_CPL[1], tlp_pkg::TYPE_CPL}:     kind = tlp_pkg::TLP_CPL;
      {tlp_pkg::FMT_CPLD[1], tlp_pkg::TYPE_CPLD}:   kind = tlp_pkg::TLP_CPLD;
      default:                                      kind = tlp_pkg::TLP_UNKNOWN;
    endcase
  end

  // Frame strobes and classification
  always_ff @(posedge clk) begin
    if (reset) begin
      frame.frm_start <= 1'b0;
      frame.frm_end   <= 1'b0;
      frame.kind      <= tlp_pkg::TLP_UNKNOWN;
      frame.is_npr    <= 1'b0;
      frame.is_pr     <= 1'b0;
    end else begin
      frame.frm_start <= accept;
      frame.frm_end   <= id_valid & rx_st_valid & rx_st_endofpacket;
      if (accept) begin
        frame.kind   <= kind;
        frame.is_npr <= 1'b0;
        frame.is_pr  <= 1'b0;
        casez ({fmt[1], raw_type})
          6'b00000?: frame.is_npr <= 1'b1; // MRd, MRdLk
          6'b?00010: frame.is_npr <= 1'b1; // IORd, IOWr
          6'b1011??: frame.is_npr <= 1'b1; // Atomics
          6'b100000: frame.is_pr  <= 1'b1; // MWr
          6'b?10???: frame.is_pr  <= 1'b1; // Msg, MsgD
          default: ;
        endcase
      end
    end
  end

  // Request header fields held until the next packet
  always_ff @(posedge clk) begin
    if (accept) begin
      frm_len            <= len;
      frm_is_4dw         <= is_4dw;
      frame.requester_id <= dword[1][31:16];
      frame.tag          <= dword[1][15:8];
      frame.byte_count   <= tlp_pkg::byte_count(len, dword[1][3:0], dword[1][7:4]);
      if (is_4dw) begin
        // Lower half of the 64-bit address only
        frame.address       <= {dword[3][31:2], 2'b00};
        frame.lower_address <= {dword[3][6:2], 2'b00};
        frame.data          <= dword[4];
      end else begin
        frame.address       <= {dword[2][31:2], 2'b00};
        frame.lower_address <= {dword[2][6:2], 2'b00};
        frame.data          <= dword[3];
      end
    end
  end

  // Only single dword 32-bit MRd/MWr are served
  always_comb begin
    frame.unsupported = 1'b0;
    if (frame.kind == tlp_pkg::TLP_UNKNOWN)
      frame.unsupported = 1'b1;
    else if (frame.kind == tlp_pkg::TLP_CPL || frame.kind == tlp_pkg::TLP_MRDLK)
      frame.unsupported = 1'b1;
    else if (frm_is_4dw)
      frame.unsupported = 1'b1;   // No 64-bit addressing
    else if (frame.kind == tlp_pkg::TLP_MRD || frame.kind == tlp_pkg::TLP_MWR) begin
      if (frm_len != tlp_pkg::LEN_W'(1))
        frame.unsupported = 1'b1;
      else if (frame.byte_count != tlp_pkg::BYTE_CNT_W'(0) &&
               frame.byte_count != tlp_pkg::BYTE_CNT_W'(4))
        frame.unsupported = 1'b1; // Partial dword access
    end
  end

endmodule

//--- tb.f
common/tlp_pkg.sv
common/tlp_frame_if.sv
rx/tlp_rx_decoder.sv
rtl/mem_request_encoder.sv
tx/cpl_builder.sv
rtl/tlp_stats_csr.sv
rtl/pcie_tlp_handler.sv
dv/tb_pcie_tlp_handler.sv

//--- tx/cpl_builder.sv
`timescale 1ns/100ps
module cpl_builder (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [tlp_pkg::REQ_ID_W-1:0]  completer_id,
  tlp_frame_if.consumer                 frame,
  input  logic [tlp_pkg::MEM_REQ_W-1:0] mem_access_resp_data,
  input  logic                          mem_access_resp_valid,
  output logic [tlp_pkg::DATA_W-1:0]    tx_st_data,
  output logic                          tx_st_valid,
  output logic                          tx_st_startofpacket,
  output logic                          tx_st_endofpacket,
  output logic [6:0]                    cpl_err
);

  logic [tlp_pkg::REQ_ID_W-1:0]  resp_requester_id;
  logic [tlp_pkg::TAG_W-1:0]     resp_tag;
  logic [6:0]                    resp_lower_address;
  logic [tlp_pkg::DW_W-1:0]      resp_rddata;
  logic [7:0][tlp_pkg::DW_W-1:0] ur_beat;
  logic [7:0][tlp_pkg::DW_W-1:0] cpld_beat;
  logic                          send_ur;

  // Memory response fields
  assign resp_requester_id  = mem_access_resp_data[15:0];
  assign resp_tag           = mem_access_resp_data[23:16];
  assign resp_lower_address = {mem_access_resp_data[28:24], 2'b00};
  assign resp_rddata        = mem_access_resp_data[63:32];

  assign send_ur = frame.frm_end & frame.is_npr & frame.unsupported;

  always_comb begin
    ur_beat = '0;
    ur_beat[0][31:29] = tlp_pkg::FMT_CPL;
    ur_beat[0][28:24] = tlp_pkg::TYPE_CPL;      // Length stays 0
    ur_beat[1][31:16] = completer_id;
    ur_beat[1][15:13] = tlp_pkg::CPL_UR;
    ur_beat[1][11:0]  = frame.byte_count;
    ur_beat[2][31:16] = frame.requester_id;
    ur_beat[2][15:8]  = frame.tag;
    ur_beat[2][6:0]   = frame.lower_address;
  end

  always_comb begin
    cpld_beat = '0;
    cpld_beat[0][31:29] = tlp_pkg::FMT_CPLD;
    cpld_beat[0][28:24] = tlp_pkg::TYPE_CPLD;
    cpld_beat[0][9:0]   = tlp_pkg::LEN_W'(1);
    cpld_beat[1][31:16] = completer_id;
    cpld_beat[1][15:13] = tlp_pkg::CPL_SC;
    cpld_beat[1][11:0]  = tlp_pkg::BYTE_CNT_W'(4);
    cpld_beat[2][31:16] = resp_requester_id;
    cpld_beat[2][15:8]  = resp_tag;
    cpld_beat[2][6:0]   = resp_lower_address;
    // 8-byte aligned data needs a pad dword after the header
    if (!resp_lower_address[2])
      cpld_beat[4] = resp_rddata;
    else
      cpld_beat[3] = resp_rddata;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_st_valid         <= 1'b0;
      tx_st_startofpacket <= 1'b0;
      tx_st_endofpacket   <= 1'b0;
    end else begin
      tx_st_valid         <= send_ur | mem_access_resp_valid; // Single beat TLPs
      tx_st_startofpacket <= send_ur | mem_access_resp_valid;
      tx_st_endofpacket   <= send_ur | mem_access_resp_valid;
    end
  end

  // UR wins a collision, the memory response is dropped
  always_ff @(posedge clk) begin
    if (send_ur)
      tx_st_data <= ur_beat;
    else if (mem_access_resp_valid)
      tx_st_data <= cpld_beat;
  end

  // Bit 5 UR non-posted, bit 4 UR posted
  assign cpl_err = {1'b0,
                    frame.frm_start & frame.unsupported & frame.is_npr,
                    frame.frm_start & frame.unsupported & frame.is_pr,
                    4'b0000};

endmodule
